//--- source/mvm_pkg.sv
package mvm_pkg;

    // operand element, one byte
    localparam int DATA_W = 8;

    // full product of two operands
    localparam int PROD_W = 2 * DATA_W;

    // row sum, holds 16 full-scale products
    localparam int ACC_W = 20;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [ACC_W-1:0]  acc_t;

    // loop controller states
    // IDLE   waiting for a start strobe
    // RUN    sweeping columns, one per cycle
    // DRAIN  last row sum still on its way to the buffer
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_t;

endpackage

//--- source/agu_next.sv
`timescale 1ns/1ps
`default_nettype none

module agu_next #(
    parameter int IDX_W = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start_i,
    input  wire logic             en_i,
    input  wire logic [IDX_W-1:0] fin_i,
    output logic      [IDX_W-1:0] data_o,
    output logic                  last_o,
    output logic                  next_o
);

    //////////////////////////////////////////////////
    // index register
    //////////////////////////////////////////////////

    // start wins over a step in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            data_o <= '0;
        end else if (start_i) begin
            data_o <= '0;
        end else if (en_i) begin
            if (last_o) begin
                data_o <= '0;
            end else begin
                data_o <= data_o + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // loop boundary
    //////////////////////////////////////////////////

    assign last_o = (data_o == fin_i);

    // wrap in progress, lets the outer loop step
    assign next_o = en_i & last_o;

endmodule

`default_nettype wire

//--- source/exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl #(
    parameter int IDX_W = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             src_v_i,
    input  wire logic [IDX_W-1:0] last_row_i,
    input  wire logic [IDX_W-1:0] last_col_i,
    output logic                  exec_o,
    output logic      [IDX_W-1:0] row_o,
    output logic      [IDX_W-1:0] col_o,
    output logic      [IDX_W-1:0] res_row_o,
    output logic                  last_col_o,
    output logic                  k_fin_o,
    output logic                  s_fin_o
);

    mvm_pkg::ctrl_state_t state;

    logic [IDX_W-1:0] fin_row;
    logic [IDX_W-1:0] fin_col;
    logic             start;
    logic             run;
    logic             last_col;
    logic             next_col;
    logic             next_row;

    // start strobes outside IDLE are dropped
    assign start = src_v_i & (state == mvm_pkg::IDLE);
    assign run   = (state == mvm_pkg::RUN);

    // bounds held for the whole job
    always_ff @(posedge clk) begin
        if (start) begin
            fin_row <= last_row_i;
            fin_col <= last_col_i;
        end
    end

    //////////////////////////////////////////////////
    // nested loop counters
    //////////////////////////////////////////////////

    // rows, stepped at the end of each column sweep
    agu_next #(.IDX_W(IDX_W)) l_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .en_i    (next_col),
        .fin_i   (fin_row),
        .data_o  (row_o),
        .last_o  (),
        .next_o  (next_row)
    );

    // columns, one per RUN cycle
    agu_next #(.IDX_W(IDX_W)) l_j (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .en_i    (run),
        .fin_i   (fin_col),
        .data_o  (col_o),
        .last_o  (last_col),
        .next_o  (next_col)
    );

    //////////////////////////////////////////////////
    // state and flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mvm_pkg::IDLE;
            k_fin_o <= 1'b0;
            s_fin_o <= 1'b0;
        end else begin
            // product of the row's last column arrives next cycle
            k_fin_o <= run & last_col;
            s_fin_o <= (state == mvm_pkg::DRAIN) & k_fin_o;
            case (state)
                mvm_pkg::IDLE: begin
                    if (src_v_i) begin
                        state <= mvm_pkg::RUN;
                    end
                end
                mvm_pkg::RUN: begin
                    // row counter wrapping means the last cell was addressed
                    if (next_row) begin
                        state <= mvm_pkg::DRAIN;
                    end
                end
                mvm_pkg::DRAIN: begin
                    if (k_fin_o) begin
                        state <= mvm_pkg::IDLE;
                    end
                end
                default: begin
                    state <= mvm_pkg::IDLE;
                end
            endcase
        end
    end

    // row index lined up with the operand read latency
    always_ff @(posedge clk) begin
        res_row_o <= row_o;
    end

    assign exec_o     = run;
    assign last_col_o = last_col;

endmodule

`default_nettype wire

//--- source/operand_mem.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mem #(
    parameter int IDX_W = 4
) (
    input  wire logic             clk,
    // host matrix writes
    input  wire logic             mat_we_i,
    input  wire logic [IDX_W-1:0] mat_row_i,
    input  wire logic [IDX_W-1:0] mat_col_i,
    input  wire mvm_pkg::data_t   mat_data_i,
    // host vector writes
    input  wire logic             vec_we_i,
    input  wire logic [IDX_W-1:0] vec_idx_i,
    input  wire mvm_pkg::data_t   vec_data_i,
    // engine reads
    input  wire logic             rd_en_i,
    input  wire logic [IDX_W-1:0] row_i,
    input  wire logic [IDX_W-1:0] col_i,
    output mvm_pkg::data_t        a_elem_o,
    output mvm_pkg::data_t        x_elem_o,
    output logic                  prod_v_o
);

    localparam int DEPTH = 2 ** IDX_W;

    mvm_pkg::data_t mat_mem [DEPTH][DEPTH];
    mvm_pkg::data_t vec_mem [DEPTH];

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mat_we_i) begin
            mat_mem[mat_row_i][mat_col_i] <= mat_data_i;
        end
        if (vec_we_i) begin
            vec_mem[vec_idx_i] <= vec_data_i;
        end
    end

    //////////////////////////////////////////////////
    // engine side, one cycle read
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            a_elem_o <= mat_mem[row_i][col_i];
            x_elem_o <= vec_mem[col_i];
        end
        // valid travels with the data
        prod_v_o <= rd_en_i;
    end

endmodule

`default_nettype wire

//--- source/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           prod_v_i,
    input  wire logic           k_fin_i,
    input  wire mvm_pkg::data_t a_elem_i,
    input  wire mvm_pkg::data_t x_elem_i,
    output logic                wr_en_o,
    output mvm_pkg::acc_t       wr_data_o
);

    mvm_pkg::prod_t prod;
    mvm_pkg::acc_t  acc;
    mvm_pkg::acc_t  acc_next;

    // unsigned product, zero extended into the sum
    assign prod     = a_elem_i * x_elem_i;
    assign acc_next = acc + mvm_pkg::acc_t'(prod);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (prod_v_i) begin
            // row done, next row starts from zero
            if (k_fin_i) begin
                acc <= '0;
            end else begin
                acc <= acc_next;
            end
        end
    end

    // row sum including the last product
    assign wr_en_o   = prod_v_i & k_fin_i;
    assign wr_data_o = acc_next;

endmodule

`default_nettype wire

//--- source/dst_buff.sv
`timescale 1ns/1ps
`default_nettype none

module dst_buff #(
    parameter int IDX_W = 4
) (
    input  wire logic             clk,
    input  wire logic             wr_en_i,
    input  wire logic [IDX_W-1:0] wr_idx_i,
    input  wire mvm_pkg::acc_t    wr_data_i,
    input  wire logic [IDX_W-1:0] rd_idx_i,
    output mvm_pkg::acc_t         rd_data_o
);

    localparam int DEPTH = 2 ** IDX_W;

    // one sum per row
    mvm_pkg::acc_t res_mem [DEPTH];

    //////////////////////////////////////////////////
    // accumulator write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            res_mem[wr_idx_i] <= wr_data_i;
        end
    end

    //////////////////////////////////////////////////
    // host read
    //////////////////////////////////////////////////

    // combinational, valid once s_fin has been seen
    assign rd_data_o = res_mem[rd_idx_i];

endmodule

`default_nettype wire

//--- source/mvm_top.sv
`timescale 1ns/1ps
`default_nettype none

module mvm_top #(
    parameter int IDX_W = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             mat_we_i,
    input  wire logic [IDX_W-1:0] mat_row_i,
    input  wire logic [IDX_W-1:0] mat_col_i,
    input  wire mvm_pkg::data_t   mat_data_i,
    input  wire logic             vec_we_i,
    input  wire logic [IDX_W-1:0] vec_idx_i,
    input  wire mvm_pkg::data_t   vec_data_i,
    input  wire logic             src_v_i,
    input  wire logic [IDX_W-1:0] last_row_i,
    input  wire logic [IDX_W-1:0] last_col_i,
    input  wire logic [IDX_W-1:0] res_idx_i,
    output logic                  exec_o,
    output logic                  k_fin_o,
    output logic                  s_fin_o,
    output mvm_pkg::acc_t         res_data_o
);

    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;
    logic [IDX_W-1:0] res_row;
    logic             exec;
    logic             k_fin;
    logic             prod_v;
    logic             wr_en;
    mvm_pkg::data_t   a_elem;
    mvm_pkg::data_t   x_elem;
    mvm_pkg::acc_t    wr_data;

    exe_ctrl #(.IDX_W(IDX_W)) exe_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .src_v_i    (src_v_i),
        .last_row_i (last_row_i),
        .last_col_i (last_col_i),
        .exec_o     (exec),
        .row_o      (row),
        .col_o      (col),
        .res_row_o  (res_row),
        .last_col_o (),
        .k_fin_o    (k_fin),
        .s_fin_o    (s_fin_o)
    );

    operand_mem #(.IDX_W(IDX_W)) operand_mem_inst (
        .clk        (clk),
        .mat_we_i   (mat_we_i),
        .mat_row_i  (mat_row_i),
        .mat_col_i  (mat_col_i),
        .mat_data_i (mat_data_i),
        .vec_we_i   (vec_we_i),
        .vec_idx_i  (vec_idx_i),
        .vec_data_i (vec_data_i),
        .rd_en_i    (exec),
        .row_i      (row),
        .col_i      (col),
        .a_elem_o   (a_elem),
        .x_elem_o   (x_elem),
        .prod_v_o   (prod_v)
    );

    mac_unit mac_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .prod_v_i  (prod_v),
        .k_fin_i   (k_fin),
        .a_elem_i  (a_elem),
        .x_elem_i  (x_elem),
        .wr_en_o   (wr_en),
        .wr_data_o (wr_data)
    );

    dst_buff #(.IDX_W(IDX_W)) dst_buff_inst (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_idx_i  (res_row),
        .wr_data_i (wr_data),
        .rd_idx_i  (res_idx_i),
        .rd_data_o (res_data_o)
    );

    assign exec_o  = exec;
    assign k_fin_o = k_fin;

endmodule

`default_nettype wire

//--- verif/mvm_clkgen.sv
`timescale 1ns/1ps

module mvm_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held over the first two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #10;
        rst_o = 1'b0;
    end

endmodule

//--- verif/mvm_assert.sv
`timescale 1ns/1ps

module mvm_assert (
    input logic clk_i,
    input logic rst_i,
    input logic exec_i,
    input logic k_fin_i,
    input logic s_fin_i
);

    //////////////////////////////////////////////////
    // controller flag protocol
    //////////////////////////////////////////////////

    // flags come out of a reset cycle low
    flags_after_reset: assert property (
        @(posedge clk_i) rst_i |=> !(exec_i || k_fin_i || s_fin_i))
        else $error("a flag is high right after a reset cycle");

    // final row of a job, exec already low
    k_fin_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i) (k_fin_i && !exec_i) |=> !k_fin_i)
        else $error("k_fin held longer than one cycle after the last row");

    s_fin_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i) s_fin_i |=> !s_fin_i)
        else $error("s_fin held longer than one cycle");

    s_fin_after_k_fin: assert property (
        @(posedge clk_i) disable iff (rst_i) s_fin_i |-> $past(k_fin_i))
        else $error("s_fin without k_fin in the cycle before");

    exec_low_after_s_fin: assert property (
        @(posedge clk_i) disable iff (rst_i) s_fin_i |=> !exec_i)
        else $error("exec high in the cycle after s_fin");

endmodule

//--- verif/mvm_tb.sv
`timescale 1ns/1ps

module mvm_tb;

    localparam int IDX_W      = 4;
    localparam int DIM        = 2 ** IDX_W;
    localparam int DRIVE_DLY  = 10;
    // full load, full sweep, flags and result reads per job
    localparam int JOB_CYCLES = 2 * DIM * DIM + 64;

    logic             clk;
    logic             rst;
    logic             mat_we_i;
    logic [IDX_W-1:0] mat_row_i;
    logic [IDX_W-1:0] mat_col_i;
    mvm_pkg::data_t   mat_data_i;
    logic             vec_we_i;
    logic [IDX_W-1:0] vec_idx_i;
    mvm_pkg::data_t   vec_data_i;
    logic             src_v_i;
    logic [IDX_W-1:0] last_row_i;
    logic [IDX_W-1:0] last_col_i;
    logic [IDX_W-1:0] res_idx_i;
    logic             exec_o;
    logic             k_fin_o;
    logic             s_fin_o;
    mvm_pkg::acc_t    res_data_o;

    // operands and expected sums of the current job
    mvm_pkg::data_t   a_mat [DIM][DIM];
    mvm_pkg::data_t   x_vec [DIM];
    mvm_pkg::acc_t    exp_sum [DIM];

    // result reads still to be made, served one per cycle
    logic [IDX_W-1:0] rd_idx_q [$];
    mvm_pkg::acc_t    rd_exp_q [$];

    logic [15:0] lfsr_state = 16'd40;
    int          fd;
    int          num_jobs = 0;
    int          err_sum = 0;
    int          err_flag = 0;
    int          err_count = 0;
    int          err_other = 0;

    mvm_clkgen #(.PERIOD_NS(100)) clkgen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    mvm_top #(.IDX_W(IDX_W)) mvm_top_inst (
        .clk        (clk),
        .rst        (rst),
        .mat_we_i   (mat_we_i),
        .mat_row_i  (mat_row_i),
        .mat_col_i  (mat_col_i),
        .mat_data_i (mat_data_i),
        .vec_we_i   (vec_we_i),
        .vec_idx_i  (vec_idx_i),
        .vec_data_i (vec_data_i),
        .src_v_i    (src_v_i),
        .last_row_i (last_row_i),
        .last_col_i (last_col_i),
        .res_idx_i  (res_idx_i),
        .exec_o     (exec_o),
        .k_fin_o    (k_fin_o),
        .s_fin_o    (s_fin_o),
        .res_data_o (res_data_o)
    );

    bind mvm_top mvm_assert mvm_assert_inst (
        .clk_i   (clk),
        .rst_i   (rst),
        .exec_i  (exec_o),
        .k_fin_i (k_fin_o),
        .s_fin_i (s_fin_o)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_acc(input mvm_pkg::acc_t exp, input mvm_pkg::acc_t act,
                             input string name);
        if (act !== exp) begin
            err_sum++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            err_flag++;
            $display("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input int exp, input int act, input string name);
        if (act != exp) begin
            err_count++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // padding source
    //////////////////////////////////////////////////

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic pad_byte(output mvm_pkg::data_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic read_num(output int v);
        int rc;
        rc = $fscanf(fd, "%d", v);
        if (rc != 1) begin
            err_other++;
            v = 0;
            $display("the test file ended early or holds a bad number");
        end
    endtask

    //////////////////////////////////////////////////
    // cycle helpers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic service_read();
        mvm_pkg::acc_t exp_val;
        if (rd_idx_q.size() > 0) begin
            res_idx_i = rd_idx_q.pop_front();
            exp_val   = rd_exp_q.pop_front();
            #1;
            check_acc(exp_val, res_data_o, $sformatf("res_data_o[%0d]", res_idx_i));
        end
    endtask

    // whole memory rewritten, cells outside the bounds get padding
    task automatic load_operands(input int lr, input int lc);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                next_cycle();
                mat_we_i  = 1'b1;
                mat_row_i = IDX_W'(r);
                mat_col_i = IDX_W'(c);
                if (r <= lr && c <= lc) begin
                    mat_data_i = a_mat[r][c];
                end else begin
                    pad_byte(mat_data_i);
                end
                vec_we_i  = (r == 0);
                vec_idx_i = IDX_W'(c);
                if (c <= lc) begin
                    vec_data_i = x_vec[c];
                end else if (r == 0) begin
                    pad_byte(vec_data_i);
                end
                service_read();
            end
        end
    endtask

    //////////////////////////////////////////////////
    // one job from the test file
    //////////////////////////////////////////////////

    task automatic run_job();
        int   mode;
        int   lr;
        int   lc;
        int   dup;
        int   v;
        int   fill_a;
        int   fill_x;
        int   rows;
        int   cols;
        int   n;
        int   k_cnt;
        int   s_cnt;
        bit   done;
        logic exp_exec;
        logic exp_k;
        logic exp_s;

        read_num(mode);
        read_num(lr);
        read_num(lc);
        read_num(dup);
        rows = lr + 1;
        cols = lc + 1;
        if (mode == 1) begin
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    read_num(v);
                    a_mat[r][c] = mvm_pkg::data_t'(v);
                end
            end
            for (int c = 0; c < cols; c++) begin
                read_num(v);
                x_vec[c] = mvm_pkg::data_t'(v);
            end
        end else if (mode == 2) begin
            read_num(fill_a);
            read_num(fill_x);
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    a_mat[r][c] = mvm_pkg::data_t'(fill_a);
                end
            end
            for (int c = 0; c < cols; c++) begin
                x_vec[c] = mvm_pkg::data_t'(fill_x);
            end
        end
        for (int r = 0; r < rows; r++) begin
            read_num(v);
            exp_sum[r] = mvm_pkg::acc_t'(v);
        end

        // mode 0 runs on the operands already in memory
        if (mode != 0) begin
            load_operands(lr, lc);
        end

        // cycle 0, start strobe
        next_cycle();
        mat_we_i   = 1'b0;
        vec_we_i   = 1'b0;
        src_v_i    = 1'b1;
        last_row_i = IDX_W'(lr);
        last_col_i = IDX_W'(lc);
        check_flag(1'b0, exec_o, "exec_o");
        service_read();

        n     = 0;
        k_cnt = 0;
        s_cnt = 0;
        done  = 1'b0;
        while (!done) begin
            next_cycle();
            n++;
            // second strobe with other bounds, must be dropped
            src_v_i    = (dup != 0 && n == 1);
            last_row_i = src_v_i ? ~IDX_W'(lr) : IDX_W'(lr);
            last_col_i = src_v_i ? ~IDX_W'(lc) : IDX_W'(lc);
            exp_exec = (n >= 1 && n <= rows * cols);
            exp_k    = (n > cols) && ((n - 1) % cols == 0) && (n <= rows * cols + 1);
            exp_s    = (n == rows * cols + 2);
            check_flag(exp_exec, exec_o, "exec_o");
            check_flag(exp_k, k_fin_o, "k_fin_o");
            check_flag(exp_s, s_fin_o, "s_fin_o");
            if (k_fin_o) begin
                k_cnt++;
            end
            if (s_fin_o) begin
                s_cnt++;
                done = 1'b1;
            end else if (n >= rows * cols + 2) begin
                err_other++;
                done = 1'b1;
                $display("s_fin_o did not arrive in cycle %0d of the job", rows * cols + 2);
            end
            service_read();
        end

        check_count(rows, k_cnt, "k_fin_o pulses");
        check_count(1, s_cnt, "s_fin_o pulses");
        for (int r = 0; r < rows; r++) begin
            rd_idx_q.push_back(IDX_W'(r));
            rd_exp_q.push_back(exp_sum[r]);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin : main
        string line;
        int    rc;

        mat_we_i   = 1'b0;
        mat_row_i  = '0;
        mat_col_i  = '0;
        mat_data_i = '0;
        vec_we_i   = 1'b0;
        vec_idx_i  = '0;
        vec_data_i = '0;
        src_v_i    = 1'b0;
        last_row_i = '0;
        last_col_i = '0;
        res_idx_i  = '0;

        fd = $fopen("verif/mvm_tests.txt", "r");
        if (fd == 0) begin
            err_other++;
            $display("cannot open verif/mvm_tests.txt");
        end else begin
            // skip the column notes at the top
            do begin
                rc = $fgets(line, fd);
            end while (rc > 0 && line.getc(0) == "#");
            rc = $sscanf(line, "%d", num_jobs);
            if (rc != 1 || num_jobs <= 0) begin
                err_other++;
                $display("the test file gives no job count");
            end else begin
                @(negedge rst);
                for (int j = 0; j < num_jobs; j++) begin
                    run_job();
                end
                while (rd_idx_q.size() > 0) begin
                    next_cycle();
                    service_read();
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d sum, %0d flag, %0d count, %0d other",
                 err_sum, err_flag, err_count, err_other);
        if (err_sum + err_flag + err_count + err_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        wait (num_jobs > 0);
        repeat (num_jobs * JOB_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 num_jobs * JOB_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verif/mvm_tests.txt
# job header: mode (0 reuse memory, 1 listed operands, 2 fill) last_row last_col repeat_start
# then matrix row-major and vector (mode 1) or fill values a x (mode 2), then expected row sums
7
1 0 0 0
200
150
30000
1 0 15 1
15 30 45 60 75 90 105 120 135 150 165 180 195 210 225 240
16 15 14 13 12 11 10 9 8 7 6 5 4 3 2 1
12240
1 15 0 0
15 31 47 63 79 95 111 127 143 159 175 191 207 223 239 255
200
3000 6200 9400 12600 15800 19000 22200 25400
28600 31800 35000 38200 41400 44600 47800 51000
2 15 15 1
255 255
1040400 1040400 1040400 1040400 1040400 1040400 1040400 1040400
1040400 1040400 1040400 1040400 1040400 1040400 1040400 1040400
0 2 3 0
260100 260100 260100
1 2 2 0
12 7 200
0 255 3
99 1 45
5 100 2
1160 25506 685
0 1 1 0
760 25500

//--- flist.f
source/mvm_pkg.sv
source/agu_next.sv
source/exe_ctrl.sv
source/operand_mem.sv
source/mac_unit.sv
source/dst_buff.sv
source/mvm_top.sv
verif/mvm_clkgen.sv
verif/mvm_assert.sv
verif/mvm_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -Wno-fatal --top-module mvm_tb -f flist.f -o mvm_sim \
    > build.log 2>&1 \
    && ./obj_dir/mvm_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && exit 0 || exit 1
